/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module dcache_tb -Mdir obj_dir -o dcache_sim

run: compile
	-./obj_dir/dcache_sim > sim.log 2>&1
	cat sim.log
	grep -q "^All tests passed!$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/dcache.sv */
// data cache: two-way set-associative write-back cache with refill, flush on halt and hit counter
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::dc_req_t  req_i,
	input  logic                 halt_i,
	output dcache_pkg::dc_rsp_t  rsp_o,
	output dcache_pkg::mem_req_t mem_req_o,
	input  dcache_pkg::mem_rsp_t mem_rsp_i,
	output logic                 flushed_o
);

	typedef struct packed {
		logic                    valid;
		logic                    dirty;
		dcache_pkg::tag_t        tag;
		dcache_pkg::word_t [1:0] data;
	} frame_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	dcache_pkg::dc_state_t   state_q, state_d;
	logic                    valid_q [2][`DC_SETS];
	logic                    dirty_q [2][`DC_SETS];
	logic                    lru_q [`DC_SETS];      // way to evict next
	dcache_pkg::tag_t        tag_q [2][`DC_SETS];
	dcache_pkg::word_t [1:0] data_q [2][`DC_SETS];
	logic signed [31:0]      cnt_q, cnt_d;          // hits minus misses
	logic [`DC_IDX_W:0]      fidx_q, fidx_d;        // msb set when walk done

	dcache_pkg::tag_t        a_tag;
	dcache_pkg::idx_t        a_idx;
	logic                    a_blk;
	dcache_pkg::idx_t        f_idx;
	frame_t                  way_f [2];
	frame_t                  fl_f;
	logic                    access, match0, match1, hit, miss;
	logic                    hit_way, vict, fl_way;
	logic                    mem_done, second;
	logic                    fill_wr, fill_end, flush_end;

	assign a_tag  = req_i.addr[31 -: `DC_TAG_W];
	assign a_idx  = req_i.addr[3 +: `DC_IDX_W];
	assign a_blk  = req_i.addr[2];       // byte offset ignored
	assign f_idx  = fidx_q[`DC_IDX_W-1:0];

	assign vict   = lru_q[a_idx];
	assign fl_way = !dirty_q[0][f_idx];  // way 0 first

	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			way_f[w].valid = valid_q[w][a_idx];
			way_f[w].dirty = dirty_q[w][a_idx];
			way_f[w].tag   = tag_q[w][a_idx];
			way_f[w].data  = data_q[w][a_idx];
		end
		fl_f.valid = valid_q[fl_way][f_idx];
		fl_f.dirty = dirty_q[fl_way][f_idx];
		fl_f.tag   = tag_q[fl_way][f_idx];
		fl_f.data  = data_q[fl_way][f_idx];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign access  = req_i.ren || req_i.wen;
	assign match0  = way_f[0].valid && (way_f[0].tag == a_tag);
	assign match1  = way_f[1].valid && (way_f[1].tag == a_tag);
	assign hit     = (state_q == dcache_pkg::IDLE) && access && (match0 || match1);
	assign miss    = (state_q == dcache_pkg::IDLE) && access && !(match0 || match1);
	assign hit_way = match1;

	assign rsp_o.hit  = hit;
	assign rsp_o.load = way_f[hit_way].data[a_blk];
	assign flushed_o  = (state_q == dcache_pkg::HALTED);

	assign mem_done  = !mem_rsp_i.dwait;
	assign second    = (state_q == dcache_pkg::WB2) || (state_q == dcache_pkg::LD2) ||
		(state_q == dcache_pkg::FLUSH2);
	assign fill_wr   = ((state_q == dcache_pkg::LD1) || (state_q == dcache_pkg::LD2)) && mem_done;
	assign fill_end  = (state_q == dcache_pkg::LD2) && mem_done;
	assign flush_end = (state_q == dcache_pkg::FLUSH2) && mem_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		state_d = state_q;
		fidx_d  = fidx_q;
		cnt_d   = cnt_q;
		case (state_q)
			dcache_pkg::IDLE:
			begin
				if (hit)
					cnt_d = cnt_q + 1;
				if (miss)
				begin
					cnt_d   = cnt_q - 1;
					state_d = way_f[vict].dirty ? dcache_pkg::WB1 : dcache_pkg::LD1;
				end
				else if (halt_i)
					state_d = dcache_pkg::CLEAN;
			end
			dcache_pkg::WB1:
				if (mem_done) state_d = dcache_pkg::WB2;
			dcache_pkg::WB2:
				if (mem_done) state_d = dcache_pkg::LD1;
			dcache_pkg::LD1:
				if (mem_done) state_d = dcache_pkg::LD2;
			dcache_pkg::LD2:
				if (mem_done) state_d = dcache_pkg::IDLE;   // hit on retry
			dcache_pkg::CLEAN:
			begin
				if (fidx_q[`DC_IDX_W])
					state_d = dcache_pkg::CNT_WR;
				else if (fl_f.dirty)
					state_d = dcache_pkg::FLUSH1;
				else
					fidx_d = fidx_q + 1'b1;                 // set is clean
			end
			dcache_pkg::FLUSH1:
				if (mem_done) state_d = dcache_pkg::FLUSH2;
			dcache_pkg::FLUSH2:
				if (mem_done) state_d = dcache_pkg::CLEAN;  // same set again
			dcache_pkg::CNT_WR:
				if (mem_done) state_d = dcache_pkg::HALTED;
			dcache_pkg::HALTED:
				state_d = dcache_pkg::HALTED;
			default:
				state_d = dcache_pkg::IDLE;
		endcase
	end

	// memory request
	always_comb
	begin
		mem_req_o = '0;
		case (state_q)
			dcache_pkg::WB1, dcache_pkg::WB2:
			begin
				mem_req_o.wen   = 1'b1;
				mem_req_o.addr  = {way_f[vict].tag, a_idx, second, 2'b00};
				mem_req_o.store = way_f[vict].data[second];
			end
			dcache_pkg::LD1, dcache_pkg::LD2:
			begin
				mem_req_o.ren  = 1'b1;
				mem_req_o.addr = {a_tag, a_idx, second, 2'b00};
			end
			dcache_pkg::FLUSH1, dcache_pkg::FLUSH2:
			begin
				mem_req_o.wen   = 1'b1;
				mem_req_o.addr  = {fl_f.tag, f_idx, second, 2'b00};
				mem_req_o.store = fl_f.data[second];
			end
			dcache_pkg::CNT_WR:
			begin
				mem_req_o.wen   = 1'b1;
				mem_req_o.addr  = `DC_CNT_ADDR;
				mem_req_o.store = dcache_pkg::word_t'(cnt_q);
			end
			default:
				mem_req_o = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state_q <= dcache_pkg::IDLE;
			fidx_q  <= '0;
			cnt_q   <= '0;
			for (int s = 0; s < `DC_SETS; s++)
			begin
				valid_q[0][s] <= 1'b0;
				valid_q[1][s] <= 1'b0;
				dirty_q[0][s] <= 1'b0;
				dirty_q[1][s] <= 1'b0;
				lru_q[s]      <= 1'b0;
			end
		end
		else
		begin
			state_q <= state_d;
			fidx_q  <= fidx_d;
			cnt_q   <= cnt_d;
			if (hit)
				lru_q[a_idx] <= !hit_way;           // other way becomes victim
			if (hit && req_i.wen)
				dirty_q[hit_way][a_idx] <= 1'b1;
			if (fill_end)
			begin
				valid_q[vict][a_idx] <= 1'b1;
				dirty_q[vict][a_idx] <= 1'b0;
			end
			if (flush_end)
				dirty_q[fl_way][f_idx] <= 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (hit && req_i.wen)
			data_q[hit_way][a_idx][a_blk] <= req_i.store;
		if (fill_wr)
			data_q[vict][a_idx][second] <= mem_rsp_i.load;
		if (fill_end)
			tag_q[vict][a_idx] <= a_tag;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	property p_req_stable;
		@(posedge CLK) disable iff (!nRST)
		(mem_req_o.ren || mem_req_o.wen) && mem_rsp_i.dwait |=> $stable(mem_req_o);
	endproperty

	a_req_stable: assert property (p_req_stable);
	a_no_rw:      assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req_o.ren && mem_req_o.wen));
	// no hit while a memory access is still pending
	a_hit_idle:   assert property (@(posedge CLK) disable iff (!nRST)
		rsp_o.hit |-> !mem_rsp_i.dwait);
	a_fl_valid:   assert property (@(posedge CLK) disable iff (!nRST)
		(state_q == dcache_pkg::FLUSH1) |-> fl_f.valid);  // only valid frames written back

endmodule

/* hdl/dcache_pkg.sv */
// data cache package: word and field types, port structs and cache FSM states
`include "dcache_defines.svh"

package dcache_pkg;

	typedef logic [31:0]            word_t;
	typedef logic [`DC_TAG_W-1:0]   tag_t;
	typedef logic [`DC_IDX_W-1:0]   idx_t;

	typedef enum logic [3:0] {
		IDLE,
		WB1,        // victim word 0
		WB2,        // victim word 1
		LD1,
		LD2,
		CLEAN,      // walks the sets on halt
		FLUSH1,
		FLUSH2,
		CNT_WR,
		HALTED
	} dc_state_t;

	// datapath side
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} dc_req_t;

	typedef struct packed {
		logic  hit;
		word_t load;
	} dc_rsp_t;

	// memory side
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_rsp_t;

endpackage

/* hdl/dcache_top.sv */
// data cache top: cache and wait-state memory controller between datapath and SRAM
`timescale 1ns/100ps

module dcache_top (
	input  logic                CLK,
	input  logic                nRST,
	input  dcache_pkg::dc_req_t req_i,
	input  logic                halt_i,
	output dcache_pkg::dc_rsp_t rsp_o,
	output logic                flushed_o,
	output logic                sram_ren_o,
	output logic                sram_wen_o,
	output dcache_pkg::word_t   sram_addr_o,
	output dcache_pkg::word_t   sram_wdata_o,
	input  dcache_pkg::word_t   sram_rdata_i
);

	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::mem_rsp_t mem_rsp;

	dcache dcache_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.req_i     (req_i),
		.halt_i    (halt_i),
		.rsp_o     (rsp_o),
		.mem_req_o (mem_req),
		.mem_rsp_i (mem_rsp),
		.flushed_o (flushed_o)
	);

	mem_ctrl mem_ctrl_i (
		.CLK          (CLK),
		.nRST         (nRST),
		.req_i        (mem_req),
		.rsp_o        (mem_rsp),
		.sram_ren_o   (sram_ren_o),
		.sram_wen_o   (sram_wen_o),
		.sram_addr_o  (sram_addr_o),
		.sram_wdata_o (sram_wdata_o),
		.sram_rdata_i (sram_rdata_i)
	);

endmodule

/* hdl/mem_ctrl.sv */
// memory controller: holds dwait for the wait states of each access and strobes a synchronous SRAM
`timescale 1ns/100ps
`include "dcache_defines.svh"

module mem_ctrl (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::mem_req_t req_i,
	output dcache_pkg::mem_rsp_t rsp_o,
	output logic                 sram_ren_o,
	output logic                 sram_wen_o,
	output dcache_pkg::word_t    sram_addr_o,
	output dcache_pkg::word_t    sram_wdata_o,
	input  dcache_pkg::word_t    sram_rdata_i
);

	typedef enum logic [1:0] {IDLE, WAIT, DONE} mc_state_t;

	localparam int CNT_W = $clog2(`DC_WAIT_STATES + 2);

	mc_state_t         state_q, state_d;
	logic [CNT_W-1:0]  cnt_q, cnt_d;
	logic [CNT_W-1:0]  need;          // cycles still owed after the strobe
	logic              access;
	logic              rd_fresh_q;    // sram data shows up this cycle
	dcache_pkg::word_t rdata_q;

	assign access = req_i.ren || req_i.wen;
	assign need   = CNT_W'(`DC_WAIT_STATES) + CNT_W'(req_i.ren);

	// strobe only in the first cycle of an access
	assign sram_ren_o   = (state_q == IDLE) && req_i.ren;
	assign sram_wen_o   = (state_q == IDLE) && req_i.wen;
	assign sram_addr_o  = req_i.addr;
	assign sram_wdata_o = req_i.store;

	assign rsp_o.dwait = ((state_q == IDLE) && access && (need != '0)) || (state_q == WAIT);
	assign rsp_o.load  = rd_fresh_q ? sram_rdata_i : rdata_q;

	always_comb
	begin
		state_d = state_q;
		cnt_d   = cnt_q;
		case (state_q)
			IDLE:
			begin
				if (access && (need == CNT_W'(1)))
					state_d = DONE;
				else if (access && (need != '0))
				begin
					state_d = WAIT;
					cnt_d   = need - CNT_W'(2);
				end
			end
			WAIT:
			begin
				if (cnt_q == '0)
					state_d = DONE;
				else
					cnt_d = cnt_q - 1'b1;
			end
			default:
				state_d = IDLE;   // DONE lasts one cycle
		endcase
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state_q    <= IDLE;
			cnt_q      <= '0;
			rd_fresh_q <= 1'b0;
		end
		else
		begin
			state_q    <= state_d;
			cnt_q      <= cnt_d;
			rd_fresh_q <= sram_ren_o;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rd_fresh_q)
			rdata_q <= sram_rdata_i;
	end

	// a new strobe only follows a cycle with no pending access
	a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		(sram_ren_o || sram_wen_o) |-> !$past(rsp_o.dwait));

endmodule

/* include/dcache_defines.svh */
// data cache defines: geometry, SRAM wait states and hit counter address
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DC_SETS        8            // sets per way
`define DC_IDX_W       3            // log2 of sets
`define DC_TAG_W       26           // 32 - idx - block offset - byte offset

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DC_WAIT_STATES 2            // extra cycles per SRAM access, 0 or more

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// halt dump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DC_CNT_ADDR    32'h0000_3100 // hit counter lands here after flush

`endif

/* testbench/dcache_tb.sv */
// data cache testbench: SRAM model, reference cache model and table-driven checks
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_tb;

	typedef enum logic [1:0] {OP_LD, OP_ST, OP_HALT} op_t;
	localparam dcache_pkg::word_t SEED = 32'hffdf;

	logic                CLK = 1'b0;
	logic                nRST;
	logic                halt;
	logic                flushed;
	logic                sram_ren, sram_wen;
	dcache_pkg::dc_req_t req;
	dcache_pkg::dc_rsp_t rsp;
	dcache_pkg::word_t   sram_addr, sram_wdata, sram_rdata;

	dcache_pkg::word_t   sram [1024];
	dcache_pkg::word_t   ref_mem [1024];                  // what the datapath should see
	dcache_pkg::word_t   wr_addr_q [$], wr_data_q [$];     // every SRAM write in order
	dcache_pkg::word_t   exp_addr_q [$], exp_data_q [$];
	op_t                 tbl_op [$];
	dcache_pkg::word_t   tbl_addr [$], tbl_data [$];

	logic                m_valid [2][`DC_SETS];
	logic                m_dirty [2][`DC_SETS];
	dcache_pkg::tag_t    m_tag [2][`DC_SETS];
	logic                m_lru [`DC_SETS];                 // way to evict next
	int                  m_hits, m_misses, errors, checks;
	dcache_pkg::word_t   rng;

	dcache_top dut_i (
		.CLK          (CLK),
		.nRST         (nRST),
		.req_i        (req),
		.halt_i       (halt),
		.rsp_o        (rsp),
		.flushed_o    (flushed),
		.sram_ren_o   (sram_ren),
		.sram_wen_o   (sram_wen),
		.sram_addr_o  (sram_addr),
		.sram_wdata_o (sram_wdata),
		.sram_rdata_i (sram_rdata)
	);

	always #50 CLK = ~CLK;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SRAM model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge CLK)
	begin
		if (sram_ren)
			sram_rdata <= sram[sram_addr[11:2]];
		if (sram_wen)
		begin
			if (sram_addr < 32'h1000)                    // counter dump only logged
				sram[sram_addr[11:2]] <= sram_wdata;
			wr_addr_q.push_back(sram_addr);
			wr_data_q.push_back(sram_wdata);
		end
	end

	function automatic dcache_pkg::word_t xorshift(input dcache_pkg::word_t x);
		dcache_pkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_word(input string name, input dcache_pkg::word_t got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input op_t op, input dcache_pkg::word_t addr, data);
		tbl_op.push_back(op);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
	endtask

	task automatic expect_block(input dcache_pkg::tag_t tag, input dcache_pkg::idx_t idx);
		dcache_pkg::word_t a;
		for (int b = 0; b < 2; b++)
		begin
			a = {tag, idx, b[0], 2'b00};
			exp_addr_q.push_back(a);
			exp_data_q.push_back(ref_mem[a[11:2]]);
		end
	endtask

	task automatic compare_writes(input int n0);
		int n;
		n = wr_addr_q.size() - n0;
		checks++;
		if (n != exp_addr_q.size())
		begin
			errors++;
			$display("%0t ns: expected %0d SRAM writes but saw %0d", $time, exp_addr_q.size(), n);
		end
		for (int i = 0; i < n && i < exp_addr_q.size(); i++)
		begin
			check_word("sram_addr_o", wr_addr_q[n0+i], exp_addr_q[i]);
			check_word("sram_wdata_o", wr_data_q[n0+i], exp_data_q[i]);
		end
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request and halt
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_req(input op_t op, input dcache_pkg::word_t addr, store);
		dcache_pkg::tag_t tag;
		dcache_pkg::idx_t idx;
		logic             pred_hit, way;
		int               n0;
		tag      = addr[31:6];
		idx      = addr[5:3];
		pred_hit = 1'b0;
		way      = m_lru[idx];
		for (int w = 0; w < 2; w++)
		begin
			if (m_valid[w][idx] && (m_tag[w][idx] == tag))
			begin
				pred_hit = 1'b1;
				way      = w[0];
			end
		end
		if (!pred_hit)
		begin
			m_misses++;
			if (m_dirty[way][idx])                       // victim goes back first
				expect_block(m_tag[way][idx], idx);
		end
		n0        = wr_addr_q.size();
		req.ren   = (op == OP_LD);
		req.wen   = (op == OP_ST);
		req.addr  = addr;
		req.store = store;
		@(negedge CLK);
		check_bit("hit", rsp.hit, pred_hit);
		while (!rsp.hit)
			@(negedge CLK);
		if (op == OP_LD)
			check_word("load", rsp.load, ref_mem[addr[11:2]]);
		else
			ref_mem[addr[11:2]] = store;
		compare_writes(n0);
		m_hits++;
		m_valid[way][idx] = 1'b1;
		m_tag[way][idx]   = tag;
		if (!pred_hit)
			m_dirty[way][idx] = 1'b0;
		if (op == OP_ST)
			m_dirty[way][idx] = 1'b1;
		m_lru[idx] = !way;
		@(posedge CLK);
		#10;
	endtask

	task automatic run_halt();
		int n0;
		n0 = wr_addr_q.size();
		for (int s = 0; s < `DC_SETS; s++)
			for (int w = 0; w < 2; w++)
				if (m_dirty[w][s])
					expect_block(m_tag[w][s], s[2:0]);
		exp_addr_q.push_back(`DC_CNT_ADDR);
		exp_data_q.push_back(dcache_pkg::word_t'(m_hits - m_misses));
		req  = '0;
		halt = 1'b1;
		@(negedge CLK);
		while (!flushed)
			@(negedge CLK);
		compare_writes(n0);
		for (int i = 0; i < 1024; i++)
			check_word("sram", sram[i], ref_mem[i]);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		int  e0;
		op_t op;
		req        = '0;
		halt       = 1'b0;
		nRST       = 1'b0;
		sram_rdata = '0;
		errors     = 0;
		checks     = 0;
		m_hits     = 0;
		m_misses   = 0;
		rng        = SEED;
		for (int i = 0; i < 1024; i++)
		begin
			sram[i]    = xorshift(SEED ^ dcache_pkg::word_t'(i << 2));
			ref_mem[i] = sram[i];
		end
		for (int s = 0; s < `DC_SETS; s++)
		begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
				m_tag[w][s]   = '0;
			end
		end
		add_entry(OP_LD, 32'h040, '0);                   // read miss then hits
		add_entry(OP_LD, 32'h040, '0);
		add_entry(OP_LD, 32'h044, '0);
		add_entry(OP_ST, 32'h044, 32'h1234_5678);
		add_entry(OP_LD, 32'h044, '0);
		add_entry(OP_ST, 32'h010, 32'haaaa_0001);        // three tags in set 2
		add_entry(OP_ST, 32'h414, 32'hbbbb_0002);
		add_entry(OP_LD, 32'h810, '0);                   // dirty eviction
		add_entry(OP_LD, 32'h014, '0);
		add_entry(OP_LD, 32'h410, '0);
		for (int i = 0; i < 48; i++)
		begin
			rng = xorshift(rng);
			add_entry(rng[5] ? OP_ST : OP_LD, {25'd0, rng[4:0], 2'b00}, xorshift(rng ^ 32'h5a5a));
		end
		add_entry(OP_HALT, '0, '0);

		repeat (2) @(posedge CLK);
		#10;
		nRST = 1'b1;
		@(negedge CLK);
		check_bit("flushed_o", flushed, 1'b0);
		check_bit("sram_wen_o", sram_wen, 1'b0);
		check_bit("sram_ren_o", sram_ren, 1'b0);
		check_bit("hit", rsp.hit, 1'b0);
		@(posedge CLK);
		#10;
		for (int t = 0; t < tbl_op.size(); t++)
		begin
			e0 = errors;
			op = tbl_op[t];
			if (op == OP_HALT)
				run_halt();
			else
				run_req(op, tbl_addr[t], tbl_data[t]);
			$display("test %0d %s addr %h: %s", t, op.name(), tbl_addr[t],
				(errors == e0) ? "ok" : "failed");
		end
		$display("%0d tests, %0d checks, %0d errors", tbl_op.size(), checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog
	initial
	begin
		int limit;
		#1;
		limit = tbl_op.size() * 60 + 500;
		repeat (limit) @(posedge CLK);
		$display("watchdog expired after %0d cycles, the DUT stopped answering", limit);
		$display("Test failures found");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hdl/dcache_pkg.sv
hdl/mem_ctrl.sv
hdl/dcache.sv
hdl/dcache_top.sv
testbench/dcache_tb.sv
